//--- hw/rv_core_pkg.sv
package rv_core_pkg;

	// register and result value
	typedef logic [63:0] xlen_t;

	// instruction word
	typedef logic [31:0] inst_t;

	// byte address into the icache space
	typedef logic [11:0] pc_t;

	// register index
	typedef logic [4:0] reg_addr_t;

	// first fetch address
	localparam pc_t RESET_PC = 12'h000;

	// pc step between instructions
	localparam pc_t INST_BYTES = 12'd4;

	// entries between fetch and execute
	localparam int QUEUE_DEPTH = 2;

endpackage

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

	// instruction fields
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// major opcodes of the supported subset
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;

	// alu funct3, shared by OP and OP_IMM
	localparam funct3_t F3_ADD = 3'b000;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_OR  = 3'b110;
	localparam funct3_t F3_AND = 3'b111;

	// branch funct3
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;

	// selects SUB over ADD in OP
	localparam funct7_t F7_SUB = 7'b0100000;

endpackage

//--- hw/rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch
	import rv_core_pkg::*;
(
	input  logic  clk,
	input  logic  rst_i,
	input  logic  jump_en_i,
	input  pc_t   jump_pc_i,
	input  logic  fq_full_i,
	input  inst_t icache_data_i,
	input  logic  icache_ready_i,
	output logic  icache_req_valid_o,
	output pc_t   icache_req_addr_o,
	output logic  fq_push_o,
	output inst_t fq_inst_o,
	output pc_t   fq_pc_o
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_DROP
	} fetch_state_t;

	fetch_state_t state_q;
	pc_t          pc_q;
	pc_t          req_addr_q;
	pc_t          pc_step;

	assign pc_step = pc_q + INST_BYTES;

	// request stays up and stable until the cache answers
	assign icache_req_valid_o = (state_q != ST_IDLE);
	assign icache_req_addr_o  = req_addr_q;

	// a response that meets a jump is thrown away
	assign fq_push_o = (state_q == ST_WAIT) && icache_ready_i && !jump_en_i;
	assign fq_inst_o = icache_data_i;
	assign fq_pc_o   = req_addr_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q    <= ST_IDLE;
			pc_q       <= RESET_PC;
			req_addr_q <= RESET_PC;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (jump_en_i) begin
						pc_q <= jump_pc_i;
					end else if (!fq_full_i) begin
						req_addr_q <= pc_q;
						state_q    <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (jump_en_i) begin
						pc_q    <= jump_pc_i;
						state_q <= icache_ready_i ? ST_IDLE : ST_DROP;
					end else if (icache_ready_i) begin
						pc_q <= pc_step;
						// back to back if the queue still has room
						if (!fq_full_i) begin
							req_addr_q <= pc_step;
						end else begin
							state_q <= ST_IDLE;
						end
					end
				end
				ST_DROP: begin
					if (jump_en_i) begin
						pc_q <= jump_pc_i;
					end
					if (icache_ready_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hw/rv_inst_queue.sv
`timescale 1ns/100ps

module rv_inst_queue
	import rv_core_pkg::*;
(
	input  logic  clk,
	input  logic  rst_i,
	input  logic  push_i,
	input  inst_t push_inst_i,
	input  pc_t   push_pc_i,
	input  logic  pop_i,
	input  logic  flush_i,
	output logic  full_o,
	output logic  head_valid_o,
	output inst_t head_inst_o,
	output pc_t   head_pc_o
);
	typedef logic [$clog2(QUEUE_DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;

	inst_t  inst_mem [QUEUE_DEPTH];
	pc_t    pc_mem   [QUEUE_DEPTH];
	ptr_t   wr_ptr_q;
	ptr_t   rd_ptr_q;
	count_t count_q;
	count_t count_nxt;
	logic   do_pop;

	function automatic ptr_t ptr_inc(ptr_t p);
		return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + ptr_t'(1);
	endfunction

	assign do_pop = pop_i && (count_q != '0);

	always_comb begin
		count_nxt = count_q;
		if (push_i && !do_pop) begin
			count_nxt = count_q + count_t'(1);
		end else if (do_pop && !push_i) begin
			count_nxt = count_q - count_t'(1);
		end
	end

	// occupancy after this edge, so fetch sees the push in progress
	assign full_o = (count_nxt >= count_t'(QUEUE_DEPTH));

	assign head_valid_o = (count_q != '0);
	assign head_inst_o  = inst_mem[rd_ptr_q];
	assign head_pc_o    = pc_mem[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			if (do_pop) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			count_q <= count_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i && !flush_i) begin
			inst_mem[wr_ptr_q] <= push_inst_i;
			pc_mem[wr_ptr_q]   <= push_pc_i;
		end
	end

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile
	import rv_core_pkg::*;
(
	input  logic      clk,
	input  reg_addr_t rs1_addr_i,
	input  reg_addr_t rs2_addr_i,
	output xlen_t     rs1_data_o,
	output xlen_t     rs2_data_o,
	input  logic      we_i,
	input  reg_addr_t rd_addr_i,
	input  xlen_t     rd_data_i
);
	// x1..x31, x0 has no storage
	xlen_t regs [1:31];

	always_ff @(posedge clk) begin
		if (we_i && (rd_addr_i != '0)) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	// no internal write-through, execute bypasses the pending write
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- hw/rv_exec.sv
`timescale 1ns/100ps

module rv_exec
	import rv_core_pkg::*, rv_isa_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  logic      head_valid_i,
	input  inst_t     head_inst_i,
	input  pc_t       head_pc_i,
	output reg_addr_t rs1_addr_o,
	output reg_addr_t rs2_addr_o,
	input  xlen_t     rs1_data_i,
	input  xlen_t     rs2_data_i,
	output logic      jump_en_o,
	output pc_t       jump_pc_o,
	output logic      retire_valid_o,
	output reg_addr_t retire_rd_o,
	output xlen_t     retire_data_o
);
	opcode_t   opcode;
	funct3_t   funct3;
	funct7_t   funct7;
	reg_addr_t rd;
	xlen_t     imm_i;
	xlen_t     imm_u;
	xlen_t     imm_b;
	xlen_t     imm_j;
	xlen_t     op1;
	xlen_t     op2;
	xlen_t     result;
	pc_t       link_pc;
	logic      writes_rd;
	logic      taken;
	logic      wb_en;

	logic      wb_valid_q;
	reg_addr_t wb_rd_q;
	xlen_t     wb_data_q;

	assign opcode     = head_inst_i[6:0];
	assign rd         = head_inst_i[11:7];
	assign funct3     = head_inst_i[14:12];
	assign rs1_addr_o = head_inst_i[19:15];
	assign rs2_addr_o = head_inst_i[24:20];
	assign funct7     = head_inst_i[31:25];

	assign imm_i = {{52{head_inst_i[31]}}, head_inst_i[31:20]};
	assign imm_u = {{32{head_inst_i[31]}}, head_inst_i[31:12], 12'b0};
	assign imm_b = {{51{head_inst_i[31]}}, head_inst_i[31], head_inst_i[7],
		head_inst_i[30:25], head_inst_i[11:8], 1'b0};
	assign imm_j = {{43{head_inst_i[31]}}, head_inst_i[31], head_inst_i[19:12],
		head_inst_i[20], head_inst_i[30:21], 1'b0};

	// bypass from the result that retires this cycle
	assign op1 = (wb_valid_q && (wb_rd_q == rs1_addr_o)) ? wb_data_q : rs1_data_i;
	assign op2 = (wb_valid_q && (wb_rd_q == rs2_addr_o)) ? wb_data_q : rs2_data_i;

	assign link_pc = head_pc_i + INST_BYTES;

	always_comb begin
		result    = '0;
		writes_rd = 1'b0;
		taken     = 1'b0;
		jump_pc_o = head_pc_i + pc_t'(imm_b);
		case (opcode)
			OPC_LUI: begin
				result    = imm_u;
				writes_rd = 1'b1;
			end
			OPC_OP_IMM: begin
				if (funct3 == F3_ADD) begin
					result    = op1 + imm_i;
					writes_rd = 1'b1;
				end
			end
			OPC_OP: begin
				writes_rd = 1'b1;
				case (funct3)
					F3_ADD:  result = (funct7 == F7_SUB) ? op1 - op2 : op1 + op2;
					F3_XOR:  result = op1 ^ op2;
					F3_OR:   result = op1 | op2;
					F3_AND:  result = op1 & op2;
					default: writes_rd = 1'b0;
				endcase
			end
			OPC_BRANCH: begin
				case (funct3)
					F3_BEQ:  taken = (op1 == op2);
					F3_BNE:  taken = (op1 != op2);
					default: taken = 1'b0;
				endcase
			end
			OPC_JAL: begin
				taken     = 1'b1;
				writes_rd = 1'b1;
				result    = xlen_t'(link_pc);
				jump_pc_o = head_pc_i + pc_t'(imm_j);
			end
			// anything else passes as a no-op
			default: ;
		endcase
	end

	assign jump_en_o = head_valid_i && taken;
	assign wb_en     = head_valid_i && writes_rd && (rd != '0);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= wb_en;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_en) begin
			wb_rd_q   <= rd;
			wb_data_q <= result;
		end
	end

	assign retire_valid_o = wb_valid_q;
	assign retire_rd_o    = wb_rd_q;
	assign retire_data_o  = wb_data_q;

endmodule

//--- hw/rv_core.sv
`timescale 1ns/100ps

module rv_core
	import rv_core_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	output logic      icache_req_valid_o,
	output pc_t       icache_req_addr_o,
	input  inst_t     icache_data_i,
	input  logic      icache_ready_i,
	output logic      cpu_jump_o,
	output logic      retire_valid_o,
	output reg_addr_t retire_rd_o,
	output xlen_t     retire_data_o
);
	// fetch to queue
	logic      fq_push;
	inst_t     fq_inst;
	pc_t       fq_pc;
	logic      fq_full;
	// queue to execute
	logic      fq_head_valid;
	inst_t     fq_head_inst;
	pc_t       fq_head_pc;
	// execute redirect
	logic      jump_en;
	pc_t       jump_pc;
	// register reads
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	xlen_t     rs1_data;
	xlen_t     rs2_data;

	assign cpu_jump_o = jump_en;

	rv_fetch fetch_inst (
		.clk               (clk               ),
		.rst_i             (rst_i             ),
		.jump_en_i         (jump_en           ),
		.jump_pc_i         (jump_pc           ),
		.fq_full_i         (fq_full           ),
		.icache_data_i     (icache_data_i     ),
		.icache_ready_i    (icache_ready_i    ),
		.icache_req_valid_o(icache_req_valid_o),
		.icache_req_addr_o (icache_req_addr_o ),
		.fq_push_o         (fq_push           ),
		.fq_inst_o         (fq_inst           ),
		.fq_pc_o           (fq_pc             )
	);

	rv_inst_queue queue_inst (
		.clk         (clk          ),
		.rst_i       (rst_i        ),
		.push_i      (fq_push      ),
		.push_inst_i (fq_inst      ),
		.push_pc_i   (fq_pc        ),
		.pop_i       (fq_head_valid),
		.flush_i     (jump_en      ),
		.full_o      (fq_full      ),
		.head_valid_o(fq_head_valid),
		.head_inst_o (fq_head_inst ),
		.head_pc_o   (fq_head_pc   )
	);

	rv_exec exec_inst (
		.clk           (clk           ),
		.rst_i         (rst_i         ),
		.head_valid_i  (fq_head_valid ),
		.head_inst_i   (fq_head_inst  ),
		.head_pc_i     (fq_head_pc    ),
		.rs1_addr_o    (rs1_addr      ),
		.rs2_addr_o    (rs2_addr      ),
		.rs1_data_i    (rs1_data      ),
		.rs2_data_i    (rs2_data      ),
		.jump_en_o     (jump_en       ),
		.jump_pc_o     (jump_pc       ),
		.retire_valid_o(retire_valid_o),
		.retire_rd_o   (retire_rd_o   ),
		.retire_data_o (retire_data_o )
	);

	// retire port is the write port
	rv_regfile regfile_inst (
		.clk       (clk           ),
		.rs1_addr_i(rs1_addr      ),
		.rs2_addr_i(rs2_addr      ),
		.rs1_data_o(rs1_data      ),
		.rs2_data_o(rs2_data      ),
		.we_i      (retire_valid_o),
		.rd_addr_i (retire_rd_o   ),
		.rd_data_i (retire_data_o )
	);

endmodule

//--- bench/rv_core_chk.sv
`timescale 1ns/100ps

module rv_core_chk
	import rv_core_pkg::*;
(
	input logic clk,
	input logic rst_i,
	input logic req_valid_i,
	input pc_t  req_addr_i,
	input logic ready_i,
	input logic jump_i,
	input logic retire_valid_i
);
	// request holds until the cache answers
	req_hold_a: assert property (
		@(posedge clk) disable iff (rst_i)
		(req_valid_i && !ready_i) |=> (req_valid_i && $stable(req_addr_i))
	) else $error("icache request changed before ready");

	// sync reset clears the outputs at the first edge
	reset_req_a: assert property (@(posedge clk) rst_i |=> !req_valid_i)
		else $error("icache request valid during reset");

	reset_retire_a: assert property (@(posedge clk) rst_i |=> !retire_valid_i)
		else $error("retire valid during reset");

	reset_jump_a: assert property (@(posedge clk) rst_i |=> !jump_i)
		else $error("jump strobe during reset");

endmodule

bind rv_core rv_core_chk chk_inst (
	.clk           (clk               ),
	.rst_i         (rst_i             ),
	.req_valid_i   (icache_req_valid_o),
	.req_addr_i    (icache_req_addr_o ),
	.ready_i       (icache_ready_i    ),
	.jump_i        (cpu_jump_o        ),
	.retire_valid_i(retire_valid_o    )
);

//--- bench/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb
	import rv_core_pkg::*, rv_isa_pkg::*;
();
	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 16;
	// about 60 executed instructions at up to 4 cycles, redirects and resets, ten times over
	localparam int MAX_CYCLES   = 4000;
	localparam funct7_t F7_BASE = 7'b0000000;

	logic      clk;
	logic      rst_i;
	logic      icache_req_valid_o;
	pc_t       icache_req_addr_o;
	inst_t     icache_data_i;
	logic      icache_ready_i;
	logic      cpu_jump_o;
	logic      retire_valid_o;
	reg_addr_t retire_rd_o;
	xlen_t     retire_data_o;

	inst_t       imem [1024];
	inst_t       prog [$];
	reg_addr_t   exp_rd [$];
	xlen_t       exp_val [$];
	int          exp_jumps;
	pc_t         loop_pc;
	int          lat_fixed;
	bit          lat_random;
	logic [31:0] lcg_state;
	bit          req_busy;
	int          wait_left;
	bit          mon_on;
	bit          jump_seen;
	bit          loop_reached;
	int          jump_count;
	int          cycle_count;
	int          errors;

	rv_core uut (
		.clk               (clk               ),
		.rst_i             (rst_i             ),
		.icache_req_valid_o(icache_req_valid_o),
		.icache_req_addr_o (icache_req_addr_o ),
		.icache_data_i     (icache_data_i     ),
		.icache_ready_i    (icache_ready_i    ),
		.cpu_jump_o        (cpu_jump_o        ),
		.retire_valid_o    (retire_valid_o    ),
		.retire_rd_o       (retire_rd_o       ),
		.retire_data_o     (retire_data_o     )
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		errors++;
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = x%0d, expected x%0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int pick_latency();
		logic [31:0] r;
		if (!lat_random) begin
			return lat_fixed;
		end
		r = lcg_next();
		return int'(r[17:16]);
	endfunction

	// instruction encoders, RV64I field layout
	function automatic inst_t lui_inst(input int rd, input int imm);
		return {imm[19:0], rd[4:0], OPC_LUI};
	endfunction

	function automatic inst_t itype_inst(input funct3_t f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], OPC_OP_IMM};
	endfunction

	function automatic inst_t rtype_inst(input funct7_t f7, input funct3_t f3, input int rd,
		input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
	endfunction

	function automatic inst_t branch_inst(input funct3_t f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic inst_t jal_inst(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	task automatic wait_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// icache model, one request at a time with 0 to 3 wait cycles
	always @(posedge clk) begin
		#DRIVE_DELAY;
		if (icache_ready_i || icache_req_valid_o !== 1'b1) begin
			req_busy = 1'b0;
		end
		icache_ready_i = 1'b0;
		if (icache_req_valid_o === 1'b1 && !req_busy) begin
			req_busy  = 1'b1;
			wait_left = pick_latency();
			// first new request after a jump goes to the jump target
			if (jump_seen) begin
				jump_seen = 1'b0;
				if (icache_req_addr_o == loop_pc) begin
					loop_reached = 1'b1;
				end
			end
		end
		if (req_busy) begin
			if (wait_left == 0) begin
				icache_ready_i = 1'b1;
				icache_data_i  = imem[icache_req_addr_o[11:2]];
			end else begin
				wait_left--;
			end
		end
	end

	// retire and jump monitor, mid cycle
	always @(negedge clk) begin
		if (mon_on) begin
			if (retire_valid_o === 1'b1) begin
				if (exp_rd.size() == 0) begin
					$display("unexpected retirement of x%0d at %0t", retire_rd_o, $time);
					abort_run();
				end else begin
					check_reg("retire_rd_o", retire_rd_o, exp_rd.pop_front());
					check_xlen("retire_data_o", retire_data_o, exp_val.pop_front());
				end
			end
			if (cpu_jump_o === 1'b1) begin
				jump_seen = 1'b1;
				if (!loop_reached) begin
					jump_count++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	task automatic load_program();
		int i;
		// unused words hold a custom opcode, a no-op for the core
		for (i = 0; i < 1024; i++) begin
			imem[i] = {i[9:0], 15'h0000, 7'b0001011};
		end
		for (i = 0; i < prog.size(); i++) begin
			imem[i] = prog[i];
		end
	endtask

	// ISA reference model, runs from RESET_PC to the self-loop JAL
	task automatic run_model();
		xlen_t     rf [32];
		pc_t       pc;
		inst_t     in;
		reg_addr_t rd;
		xlen_t     a;
		xlen_t     b;
		xlen_t     val;
		int        boff;
		int        joff;
		bit        wr;
		bit        taken;
		bit        halted;
		int        i;
		for (i = 0; i < 32; i++) begin
			rf[i] = '0;
		end
		exp_rd.delete();
		exp_val.delete();
		exp_jumps = 0;
		pc        = RESET_PC;
		halted    = 1'b0;
		i         = 0;
		while (!halted) begin
			in    = imem[pc[11:2]];
			rd    = in[11:7];
			a     = rf[in[19:15]];
			b     = rf[in[24:20]];
			boff  = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
			joff  = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
			wr    = 1'b0;
			taken = 1'b0;
			val   = '0;
			case (in[6:0])
				OPC_LUI: begin
					val = {{32{in[31]}}, in[31:12], 12'h000};
					wr  = 1'b1;
				end
				OPC_OP_IMM: begin
					wr  = (in[14:12] == F3_ADD);
					val = a + {{52{in[31]}}, in[31:20]};
				end
				OPC_OP: begin
					wr = 1'b1;
					case (in[14:12])
						F3_ADD:  val = (in[31:25] == F7_SUB) ? a - b : a + b;
						F3_XOR:  val = a ^ b;
						F3_OR:   val = a | b;
						F3_AND:  val = a & b;
						default: wr = 1'b0;
					endcase
				end
				OPC_BRANCH: begin
					taken = (in[14:12] == F3_BEQ && a == b) || (in[14:12] == F3_BNE && a != b);
				end
				OPC_JAL: begin
					val   = {52'h0, pc + INST_BYTES};
					wr    = 1'b1;
					taken = 1'b1;
					boff  = joff;
					if (joff == 0) begin
						halted  = 1'b1;
						loop_pc = pc;
					end
				end
				default: ;
			endcase
			if (wr && rd != 5'd0) begin
				rf[rd] = val;
				exp_rd.push_back(rd);
				exp_val.push_back(val);
			end
			if (taken) begin
				exp_jumps++;
			end
			pc = taken ? pc + boff[11:0] : pc + INST_BYTES;
			i++;
			if (i > 500) begin
				$display("reference model never reached the final self-loop");
				abort_run();
			end
		end
	endtask

	task automatic quiet_outputs();
		check_bit("icache_req_valid_o", icache_req_valid_o, 1'b0);
		check_bit("retire_valid_o", retire_valid_o, 1'b0);
		check_bit("cpu_jump_o", cpu_jump_o, 1'b0);
	endtask

	task automatic apply_reset();
		mon_on       = 1'b0;
		jump_seen    = 1'b0;
		loop_reached = 1'b0;
		jump_count   = 0;
		rst_i        = 1'b1;
		repeat (RESET_CYCLES) begin
			wait_cycle();
			quiet_outputs();
		end
		rst_i = 1'b0;
	endtask

	task automatic run_program(input int lat, input bit rnd);
		lat_fixed  = lat;
		lat_random = rnd;
		load_program();
		run_model();
		apply_reset();
		mon_on = 1'b1;
		while (exp_rd.size() != 0 || !loop_reached) begin
			wait_cycle();
		end
		check_count("cpu_jump_o cycles", jump_count, exp_jumps);
		mon_on = 1'b0;
	endtask

	task automatic alu_program();
		prog.delete();
		prog.push_back(lui_inst(1, 'h12345));
		prog.push_back(itype_inst(F3_ADD, 1, 1, 'h678));
		prog.push_back(itype_inst(F3_ADD, 2, 0, -1));
		prog.push_back(rtype_inst(F7_BASE, F3_ADD, 3, 1, 2));
		prog.push_back(rtype_inst(F7_SUB, F3_ADD, 4, 3, 1));
		prog.push_back(rtype_inst(F7_BASE, F3_AND, 5, 4, 1));
		prog.push_back(rtype_inst(F7_BASE, F3_OR, 6, 5, 3));
		prog.push_back(rtype_inst(F7_BASE, F3_XOR, 7, 6, 2));
		prog.push_back(lui_inst(8, 'h80000));
		prog.push_back(rtype_inst(F7_SUB, F3_ADD, 9, 0, 8));
		prog.push_back(rtype_inst(F7_BASE, F3_ADD, 10, 9, 9));
		prog.push_back(jal_inst(0, 0));
	endtask

	task automatic branch_program();
		prog.delete();
		prog.push_back(itype_inst(F3_ADD, 1, 0, 5));
		prog.push_back(itype_inst(F3_ADD, 2, 0, 5));
		prog.push_back(branch_inst(F3_BEQ, 1, 2, 8));
		prog.push_back(itype_inst(F3_ADD, 3, 0, 99));
		prog.push_back(branch_inst(F3_BNE, 1, 2, 8));
		prog.push_back(itype_inst(F3_ADD, 4, 0, 11));
		prog.push_back(itype_inst(F3_ADD, 2, 2, 1));
		prog.push_back(branch_inst(F3_BEQ, 1, 2, 8));
		prog.push_back(branch_inst(F3_BNE, 1, 2, 8));
		prog.push_back(itype_inst(F3_ADD, 5, 0, 77));
		prog.push_back(jal_inst(6, 8));
		prog.push_back(itype_inst(F3_ADD, 7, 0, 1));
		// short backward loop, taken once
		prog.push_back(itype_inst(F3_ADD, 9, 0, 2));
		prog.push_back(itype_inst(F3_ADD, 9, 9, -1));
		prog.push_back(branch_inst(F3_BNE, 9, 0, -4));
		prog.push_back(rtype_inst(F7_BASE, F3_ADD, 8, 6, 4));
		prog.push_back(jal_inst(0, 0));
	endtask

	task automatic x0_program();
		prog.delete();
		prog.push_back(lui_inst(1, 'habc));
		prog.push_back(itype_inst(F3_ADD, 0, 0, 55));
		prog.push_back(rtype_inst(F7_BASE, F3_ADD, 0, 1, 1));
		prog.push_back(lui_inst(0, 'h12345));
		// ld, slti and sll are outside the subset
		prog.push_back(32'h0000_3083);
		prog.push_back(itype_inst(3'b010, 2, 1, 1));
		prog.push_back(rtype_inst(F7_BASE, 3'b001, 6, 1, 1));
		prog.push_back(itype_inst(F3_ADD, 3, 0, 7));
		prog.push_back(rtype_inst(F7_BASE, F3_ADD, 4, 1, 0));
		prog.push_back(rtype_inst(F7_SUB, F3_ADD, 5, 0, 1));
		prog.push_back(jal_inst(0, 0));
	endtask

	task automatic reset_behaviour();
		alu_program();
		load_program();
		lat_fixed  = 0;
		lat_random = 1'b0;
		apply_reset();
		@(negedge clk);
		quiet_outputs();
		wait_cycle();
		while (icache_req_valid_o !== 1'b1) begin
			wait_cycle();
		end
		check_pc("icache_req_addr_o", icache_req_addr_o, RESET_PC);
	endtask

	task automatic alu_zero_latency();
		alu_program();
		run_program(0, 1'b0);
	endtask

	task automatic alu_random_latency();
		alu_program();
		run_program(0, 1'b1);
	endtask

	task automatic branch_and_jump();
		branch_program();
		run_program(1, 1'b0);
	endtask

	task automatic x0_and_unsupported();
		x0_program();
		run_program(0, 1'b1);
	endtask

	initial begin
		rst_i          = 1'b1;
		icache_ready_i = 1'b0;
		icache_data_i  = '0;
		lcg_state      = 32'hb6bd;
		req_busy       = 1'b0;
		wait_left      = 0;
		mon_on         = 1'b0;
		jump_seen      = 1'b0;
		loop_reached   = 1'b0;
		jump_count     = 0;
		loop_pc        = RESET_PC;
		cycle_count    = 0;
		errors         = 0;
		reset_behaviour();
		alu_zero_latency();
		alu_random_latency();
		branch_and_jump();
		x0_and_unsupported();
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- filelist.f
hw/rv_core_pkg.sv
hw/rv_isa_pkg.sv
hw/rv_fetch.sv
hw/rv_inst_queue.sv
hw/rv_regfile.sv
hw/rv_exec.sv
hw/rv_core.sv
bench/rv_core_chk.sv
bench/rv_core_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := rv_core_tb
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "no pass verdict in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
